// ==== rtl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// one nibble per register and per ram word
`define CPU_DATA_W 4

// rom and ram use the same address width
`define CPU_ADDR_W 12

`define CPU_SP_W 8 // stack sits in the low 256 nibbles

// first fetch after reset
`define CPU_RESET_PC 12'h100

`define CPU_INSTR_CYCLES 5 // every opcode, nop included

`endif

// ==== rtl/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

  // instruction groups handled by this core
  typedef enum logic [2:0] {
    op_nop,
    op_push,
    op_pop,
    op_ld_ri,
    op_ld_xhl,
    op_ld_yhl
  } opclass_t;

  // low nibble of the push and pop opcodes
  typedef enum logic [3:0] {
    a  = 4'd0,
    b  = 4'd1,
    mx = 4'd2,  // ram at x
    my = 4'd3,  // ram at y
    xp = 4'd4,
    xh = 4'd5,
    xl = 4'd6,
    yp = 4'd7,
    yh = 4'd8,
    yl = 4'd9,
    f  = 4'd10
  } operand_t;

  // opcode prefixes
  localparam logic [7:0] push_prefix   = 8'hfc;
  localparam logic [7:0] pop_prefix    = 8'hfd;
  localparam logic [3:0] ld_ri_prefix  = 4'he; // bits 7:6 must be clear too
  localparam logic [3:0] ld_xhl_prefix = 4'hb;
  localparam logic [3:0] ld_yhl_prefix = 4'h8;

endpackage

`default_nettype wire

// ==== rtl/cpu_exec_pkg.sv ====
`default_nettype none

package cpu_exec_pkg;

  // one phase per clock, five clocks per instruction
  typedef enum logic [2:0] {
    ph_fetch   = 3'd0,
    ph_decode  = 3'd1,
    ph_operand = 3'd2,
    ph_access  = 3'd3,
    ph_retire  = 3'd4
  } phase_t;

  // ram operation for the current phase
  typedef enum logic [2:0] {
    mem_none,
    mem_read_operand,   // mx or my read ahead of a push
    mem_write_stack,
    mem_read_stack,
    mem_write_indirect  // store through x or y
  } memop_t;

endpackage

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module instr_decoder
  import cpu_isa_pkg::*;
  import cpu_exec_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [11:0]            rom_data,
  output logic [`CPU_ADDR_W-1:0] rom_addr,
  output phase_t                 phase,
  output opclass_t               opclass,
  output operand_t               operand,
  output logic [7:0]             imm8,
  output memop_t                 memop,
  output logic                   retire
);

  logic [`CPU_ADDR_W-1:0] pc;
  logic [11:0]            ir;
  logic                   ind_operand;

  assign rom_addr = pc;
  assign retire   = (phase == ph_retire);

  // phase sequencer and pc
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= ph_fetch;
      pc    <= `CPU_RESET_PC;
    end else begin
      case (phase)
        ph_fetch:   phase <= ph_decode;
        ph_decode:  phase <= ph_operand;
        ph_operand: phase <= ph_access;
        ph_access:  phase <= ph_retire;
        default:    phase <= ph_fetch;
      endcase
      if (phase == ph_retire) begin
        pc <= pc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (phase == ph_fetch) begin
      ir <= rom_data;
    end
  end

  assign imm8 = ir[7:0];

  always_comb begin
    opclass = op_nop;
    operand = a;
    if (ir[11:4] == push_prefix && ir[3:0] <= f) begin
      opclass = op_push;
      operand = operand_t'(ir[3:0]);
    end else if (ir[11:4] == pop_prefix && ir[3:0] <= f) begin
      opclass = op_pop;
      operand = operand_t'(ir[3:0]);
    end else if (ir[11:8] == ld_ri_prefix && ir[7:6] == 2'b00) begin
      opclass = op_ld_ri;
      operand = operand_t'({2'b00, ir[5:4]}); // a, b, mx or my
    end else if (ir[11:8] == ld_xhl_prefix) begin
      opclass = op_ld_xhl;
    end else if (ir[11:8] == ld_yhl_prefix) begin
      opclass = op_ld_yhl;
    end
  end

  assign ind_operand = (operand == mx) || (operand == my);

  // main op of the instruction, with per-phase overrides for mx/my
  always_comb begin
    case (opclass)
      op_push:  memop = mem_write_stack;
      op_pop:   memop = mem_read_stack;
      op_ld_ri: memop = ind_operand ? mem_write_indirect : mem_none;
      default:  memop = mem_none;
    endcase
    if (ind_operand && opclass == op_push && phase == ph_operand) begin
      memop = mem_read_operand;
    end
    if (ind_operand && opclass == op_pop && phase == ph_access) begin
      memop = mem_write_indirect; // popped nibble goes out through x or y
    end
    if (phase == ph_fetch) begin
      memop = mem_none; // fields still hold the previous opcode
    end
  end

  a_phase_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (phase == ph_fetch) |=> (phase == ph_decode) ##1 (phase == ph_operand)
      ##1 (phase == ph_access) ##1 (phase == ph_retire) ##1 (phase == ph_fetch));

  a_retire_pace: assert property (@(posedge clk) disable iff (!rst_n)
    retire |-> (phase == ph_retire) ##(`CPU_INSTR_CYCLES) retire);

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module reg_file
  import cpu_isa_pkg::*;
  import cpu_exec_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  phase_t                 phase,
  input  opclass_t               opclass,
  input  operand_t               operand,
  input  logic [7:0]             imm8,
  input  logic [`CPU_DATA_W-1:0] load_value,
  output logic [`CPU_DATA_W-1:0] src_value,
  output logic [`CPU_ADDR_W-1:0] x_addr,
  output logic [`CPU_ADDR_W-1:0] y_addr
);

  logic [`CPU_DATA_W-1:0] a_reg;
  logic [`CPU_DATA_W-1:0] b_reg;
  logic [`CPU_ADDR_W-1:0] x_reg; // xp xh xl
  logic [`CPU_ADDR_W-1:0] y_reg; // yp yh yl
  logic [`CPU_DATA_W-1:0] f_reg; // interrupt decimal zero carry

  assign x_addr = x_reg;
  assign y_addr = y_reg;

  // nibble for push
  always_comb begin
    case (operand)
      a:       src_value = a_reg;
      b:       src_value = b_reg;
      mx, my:  src_value = load_value; // read in ph_operand
      xp:      src_value = x_reg[11:8];
      xh:      src_value = x_reg[7:4];
      xl:      src_value = x_reg[3:0];
      yp:      src_value = y_reg[11:8];
      yh:      src_value = y_reg[7:4];
      yl:      src_value = y_reg[3:0];
      f:       src_value = f_reg;
      default: src_value = '0;
    endcase
  end

  // write-back, retire only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_reg <= '0;
      b_reg <= '0;
      x_reg <= '0;
      y_reg <= '0;
      f_reg <= '0;
    end else if (phase == ph_retire) begin
      case (opclass)
        op_pop: begin
          case (operand)
            a:       a_reg <= load_value;
            b:       b_reg <= load_value;
            xp:      x_reg[11:8] <= load_value;
            xh:      x_reg[7:4] <= load_value;
            xl:      x_reg[3:0] <= load_value;
            yp:      y_reg[11:8] <= load_value;
            yh:      y_reg[7:4] <= load_value;
            yl:      y_reg[3:0] <= load_value;
            f:       f_reg <= load_value;
            default: ; // mx and my land in ram
          endcase
        end
        op_ld_ri: begin
          if (operand == a) begin
            a_reg <= imm8[3:0];
          end else if (operand == b) begin
            b_reg <= imm8[3:0];
          end
        end
        op_ld_xhl: x_reg[7:0] <= imm8;
        op_ld_yhl: y_reg[7:0] <= imm8;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/stack_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module stack_unit
  import cpu_isa_pkg::*;
  import cpu_exec_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  phase_t                 phase,
  input  memop_t                 memop,
  input  operand_t               operand,
  input  logic [7:0]             imm8,
  input  logic [`CPU_DATA_W-1:0] src_value,
  input  logic [`CPU_ADDR_W-1:0] x_addr,
  input  logic [`CPU_ADDR_W-1:0] y_addr,
  input  logic [`CPU_DATA_W-1:0] ram_rdata,
  output logic [`CPU_ADDR_W-1:0] ram_addr,
  output logic [`CPU_DATA_W-1:0] ram_wdata,
  output logic                   ram_we,
  output logic [`CPU_DATA_W-1:0] load_value
);

  logic [`CPU_SP_W-1:0]   sp;
  logic [`CPU_ADDR_W-1:0] sp_addr;
  logic                   stack_rd; // pop read done early, pop into mx/my
  logic                   rd_phase;

  assign sp_addr = {{(`CPU_ADDR_W - `CPU_SP_W){1'b0}}, sp};

  always_comb begin
    case (memop)
      mem_read_operand, mem_write_indirect: ram_addr = (operand == my) ? y_addr : x_addr;
      default: ram_addr = sp_addr;
    endcase
  end

  assign ram_we = (phase == ph_access) &&
                  (memop == mem_write_stack || memop == mem_write_indirect);

  // indirect store takes the popped nibble or the immediate
  assign ram_wdata = (memop != mem_write_indirect) ? src_value :
                     stack_rd                      ? load_value : imm8[3:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sp       <= '0;
      stack_rd <= 1'b0;
    end else begin
      if (phase == ph_operand) begin
        stack_rd <= (memop == mem_read_stack);
        if (memop == mem_write_stack || memop == mem_read_operand) begin
          sp <= sp - 1'b1; // every push
        end
      end
      if (phase == ph_retire && memop == mem_read_stack) begin
        sp <= sp + 1'b1;
      end
    end
  end

  assign rd_phase = (phase == ph_operand) || (phase == ph_access);

  always_ff @(posedge clk) begin
    if (rd_phase && (memop == mem_read_operand || memop == mem_read_stack)) begin
      load_value <= ram_rdata;
    end
  end

  a_we_single: assert property (@(posedge clk) disable iff (!rst_n)
    ram_we |-> (phase == ph_access) ##1 !ram_we);

  // push write lands one below the old sp
  a_push_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (phase == ph_operand && (memop == mem_write_stack || memop == mem_read_operand))
      |=> (ram_we && ram_addr == {{(`CPU_ADDR_W - `CPU_SP_W){1'b0}}, $past(sp) - 1'b1}));

endmodule

`default_nettype wire

// ==== rtl/cpu_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_core
  import cpu_isa_pkg::*;
  import cpu_exec_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [11:0]            rom_data,
  output logic [`CPU_ADDR_W-1:0] rom_addr,
  output logic [`CPU_ADDR_W-1:0] ram_addr,
  output logic [`CPU_DATA_W-1:0] ram_wdata,
  output logic                   ram_we,
  input  logic [`CPU_DATA_W-1:0] ram_rdata,
  output logic                   retire
);

  phase_t                 phase;
  opclass_t               opclass;
  operand_t               operand;
  logic [7:0]             imm8;
  memop_t                 memop;
  logic [`CPU_DATA_W-1:0] src_value;
  logic [`CPU_DATA_W-1:0] load_value;
  logic [`CPU_ADDR_W-1:0] x_addr;
  logic [`CPU_ADDR_W-1:0] y_addr;

  instr_decoder u_decoder (
    .clk      (clk),
    .rst_n    (rst_n),
    .rom_data (rom_data),
    .rom_addr (rom_addr),
    .phase    (phase),
    .opclass  (opclass),
    .operand  (operand),
    .imm8     (imm8),
    .memop    (memop),
    .retire   (retire)
  );

  reg_file u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .phase      (phase),
    .opclass    (opclass),
    .operand    (operand),
    .imm8       (imm8),
    .load_value (load_value),
    .src_value  (src_value),
    .x_addr     (x_addr),
    .y_addr     (y_addr)
  );

  stack_unit u_stack (
    .clk        (clk),
    .rst_n      (rst_n),
    .phase      (phase),
    .memop      (memop),
    .operand    (operand),
    .imm8       (imm8),
    .src_value  (src_value),
    .x_addr     (x_addr),
    .y_addr     (y_addr),
    .ram_rdata  (ram_rdata),
    .ram_addr   (ram_addr),
    .ram_wdata  (ram_wdata),
    .ram_we     (ram_we),
    .load_value (load_value)
  );

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
  parameter int HALF_PERIOD  = 10, // 20 ns clock
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// ==== tests/cpu_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_core_tb;

  localparam int N_INSTR       = 200;
  localparam int CLK_PERIOD_NS = 20;
  localparam int WATCHDOG_NS   = N_INSTR * `CPU_INSTR_CYCLES * CLK_PERIOD_NS * 2;

  localparam logic [11:0] FIRST_FETCH  = 12'h100;
  localparam int          INSTR_CLOCKS = 5;

  localparam int T_PACING = 0;
  localparam int T_PUSH   = 1;
  localparam int T_IND    = 2;
  localparam int T_ROUND  = 3;
  localparam int T_NOP    = 4;

  localparam logic [3:0] OPR_MX = 4'd2;
  localparam logic [3:0] OPR_MY = 4'd3;
  localparam logic [3:0] OPR_F  = 4'd10;

  logic        clk;
  logic        rst_n;
  logic [11:0] rom_data;
  logic [11:0] rom_addr;
  logic [11:0] ram_addr;
  logic [3:0]  ram_wdata;
  logic        ram_we;
  logic [3:0]  ram_rdata;
  logic        retire;

  logic [11:0] rom_mem [0:4095];
  logic [3:0]  ram_mem [0:4095];
  logic [3:0]  model_ram [0:4095];
  logic        popped [0:15]; // operand last written by a pop

  logic [11:0] model_pc;
  logic [11:0] model_x;
  logic [11:0] model_y;
  logic [3:0]  model_a;
  logic [3:0]  model_b;
  logic [3:0]  model_f;
  logic [7:0]  model_sp;

  logic [31:0] lfsr_state;
  int          checks [0:4];
  int          errors [0:4];
  int          retired;
  int          clocks_seen;
  int          wr_count;
  logic [11:0] wr_addr;
  logic [3:0]  wr_data;
  logic        fetch_due;

  clock_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cpu_core DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .rom_data  (rom_data),
    .rom_addr  (rom_addr),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_we    (ram_we),
    .ram_rdata (ram_rdata),
    .retire    (retire)
  );

  assign rom_data  = rom_mem[rom_addr];
  assign ram_rdata = ram_mem[ram_addr];

  always @(posedge clk) begin
    if (ram_we) begin
      ram_mem[ram_addr] <= ram_wdata;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [11:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[10:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic string test_name(input int t);
    case (t)
      T_PACING: return "retire_pacing";
      T_PUSH:   return "push_registers";
      T_IND:    return "push_indirect";
      T_ROUND:  return "pop_push_round_trip";
      default:  return "nop_opcodes";
    endcase
  endfunction

  task automatic check_value(input int t, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks[t]++;
    if (exp !== act) begin
      errors[t]++;
      $display("FAILED %s: %s expected %0h, actual %0h", test_name(t), what, exp, act);
    end
  endtask

  task automatic init_memories();
    logic [11:0] addr;
    for (int i = 0; i < 4096; i++) begin
      addr = i[11:0];
      rom_mem[i]   = {1'b0, addr[10:0] ^ {addr[11], 10'b0}}; // top nibble 0..7, all nops
      ram_mem[i]   = addr[3:0] ^ addr[7:4] ^ addr[11:8] ^ 4'h9;
      model_ram[i] = addr[3:0] ^ addr[7:4] ^ addr[11:8] ^ 4'h9;
    end
  endtask

  task automatic build_program();
    logic [11:0] kind;
    logic [11:0] v;
    logic [11:0] op;
    for (int k = 0; k < N_INSTR; k++) begin
      take_bits(3, kind);
      case (kind[2:0])
        3'd0, 3'd1, 3'd2, 3'd3: begin
          take_bits(4, v);
          if (v[3:0] > 4'd10) begin
            v[3:0] = v[3:0] - 4'd5;
          end
          op = {7'b1111110, kind[1], v[3:0]}; // fc push, fd pop
        end
        3'd4: begin
          take_bits(6, v);
          op = {4'he, 2'b00, v[5:0]};
        end
        3'd5: begin
          take_bits(8, v);
          op = {4'hb, v[7:0]};
        end
        3'd6: begin
          take_bits(8, v);
          op = {4'h8, v[7:0]};
        end
        default: begin
          take_bits(11, v);
          if (v[10]) begin
            op = {7'b1111110, v[9], 4'hb + {2'b00, v[1:0]}}; // operand past f
          end else begin
            op = {1'b0, v[10:0]};
          end
        end
      endcase
      rom_mem[`CPU_RESET_PC + k] = op;
    end
    rom_mem[`CPU_RESET_PC]     = 12'hfc0; // sp wraps to ff
    rom_mem[`CPU_RESET_PC + 1] = 12'hfd0; // and back to 00
    rom_mem[`CPU_RESET_PC + 2] = 12'hb5a;
    rom_mem[`CPU_RESET_PC + 3] = 12'he27; // mx = 7
    rom_mem[`CPU_RESET_PC + 4] = 12'hfc2;
  endtask

  function automatic logic [3:0] read_operand(input logic [3:0] sel);
    case (sel)
      4'd0:    return model_a;
      4'd1:    return model_b;
      4'd2:    return model_ram[model_x];
      4'd3:    return model_ram[model_y];
      4'd4:    return model_x[11:8];
      4'd5:    return model_x[7:4];
      4'd6:    return model_x[3:0];
      4'd7:    return model_y[11:8];
      4'd8:    return model_y[7:4];
      4'd9:    return model_y[3:0];
      default: return model_f;
    endcase
  endfunction

  task automatic write_operand(input logic [3:0] sel, input logic [3:0] val);
    case (sel)
      4'd0:    model_a = val;
      4'd1:    model_b = val;
      4'd2:    model_ram[model_x] = val;
      4'd3:    model_ram[model_y] = val;
      4'd4:    model_x[11:8] = val;
      4'd5:    model_x[7:4] = val;
      4'd6:    model_x[3:0] = val;
      4'd7:    model_y[11:8] = val;
      4'd8:    model_y[7:4] = val;
      4'd9:    model_y[3:0] = val;
      default: model_f = val;
    endcase
  endtask

  // runs one instruction on the model and compares the ram write it saw
  task automatic execute_model();
    logic [11:0] op;
    logic [3:0]  sel;
    logic [3:0]  val;
    logic        exp_we;
    logic [11:0] exp_addr;
    logic        ind;
    int          t;
    op       = rom_mem[model_pc];
    sel      = op[3:0];
    val      = '0;
    exp_we   = 1'b0;
    exp_addr = '0;
    t        = T_NOP;
    if (op[11:4] == 8'hfc && sel <= OPR_F) begin
      ind = (sel == OPR_MX) || (sel == OPR_MY);
      t = ind ? T_IND : (popped[sel] ? T_ROUND : T_PUSH);
      val = read_operand(sel);
      model_sp = model_sp - 8'd1;
      exp_we = 1'b1;
      exp_addr = {4'h0, model_sp};
      model_ram[exp_addr] = val;
    end else if (op[11:4] == 8'hfd && sel <= OPR_F) begin
      t = T_ROUND;
      val = model_ram[{4'h0, model_sp}];
      if (sel == OPR_MX || sel == OPR_MY) begin
        exp_we = 1'b1;
        exp_addr = (sel == OPR_MY) ? model_y : model_x;
      end else begin
        popped[sel] = 1'b1;
      end
      write_operand(sel, val);
      model_sp = model_sp + 8'd1;
    end else if (op[11:8] == 4'he && op[7:6] == 2'b00) begin
      sel = {2'b00, op[5:4]};
      val = op[3:0];
      t = T_PUSH;
      if (sel == OPR_MX || sel == OPR_MY) begin
        t = T_IND;
        exp_we = 1'b1;
        exp_addr = (sel == OPR_MY) ? model_y : model_x;
      end
      popped[sel] = 1'b0;
      write_operand(sel, val);
    end else if (op[11:8] == 4'hb) begin
      t = T_IND;
      model_x[7:0] = op[7:0];
      popped[5] = 1'b0;
      popped[6] = 1'b0;
    end else if (op[11:8] == 4'h8) begin
      t = T_IND;
      model_y[7:0] = op[7:0];
      popped[8] = 1'b0;
      popped[9] = 1'b0;
    end
    check_value(t, "ram write count", exp_we, wr_count);
    if (exp_we && wr_count == 1) begin
      check_value(t, "ram write address", exp_addr, wr_addr);
      check_value(t, "ram write data", val, wr_data);
    end
    model_pc = model_pc + 12'd1;
  endtask

  // outputs sampled on the falling edge, half a clock after they settle
  always @(negedge clk) begin
    if (rst_n && retired < N_INSTR) begin
      clocks_seen++;
      if (fetch_due) begin
        check_value(T_PACING, "fetch address", model_pc, rom_addr);
        fetch_due = 1'b0;
      end
      if (ram_we) begin
        wr_count++;
        wr_addr = ram_addr;
        wr_data = ram_wdata;
      end
      if (retire) begin
        check_value(T_PACING, "clocks per instruction", INSTR_CLOCKS, clocks_seen);
        execute_model();
        clocks_seen = 0;
        wr_count    = 0;
        fetch_due   = 1'b1;
        retired++;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: only %0d of %0d instructions retired", retired, N_INSTR);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    int total_checks;
    int total_errors;
    lfsr_state   = 32'ha4522e2b;
    model_pc     = FIRST_FETCH;
    model_x      = '0;
    model_y      = '0;
    model_a      = '0;
    model_b      = '0;
    model_f      = '0;
    model_sp     = '0;
    retired      = 0;
    clocks_seen  = 0;
    wr_count     = 0;
    wr_addr      = '0;
    wr_data      = '0;
    fetch_due    = 1'b1;
    total_checks = 0;
    total_errors = 0;
    for (int i = 0; i < 16; i++) begin
      popped[i] = 1'b0;
    end
    for (int t = 0; t < 5; t++) begin
      checks[t] = 0;
      errors[t] = 0;
    end
    init_memories();
    build_program();
    while (retired < N_INSTR) begin
      @(negedge clk);
    end
    for (int t = 0; t < 5; t++) begin
      if (checks[t] == 0) begin
        errors[t]++;
        $display("%s: the program never exercised this test", test_name(t));
      end
      $display("test %-20s %0d checks, %0d errors, %s", test_name(t), checks[t], errors[t],
               (errors[t] == 0) ? "ok" : "not ok");
      total_checks += checks[t];
      total_errors += errors[t];
    end
    $display("total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/cpu_exec_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/stack_unit.sv
rtl/cpu_core.sv
tests/clock_gen.sv
tests/cpu_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module cpu_core_tb \
  -f verilog.f \
  -o cpu_core_sim

./obj_dir/cpu_core_sim > sim.log
cat sim.log

grep -q "Testbench passed" sim.log
echo "simulation ok"
